// File: design/smi_cfg.svh
`ifndef SMI_CFG_SVH
`define SMI_CFG_SVH

// clk cycles between finalCycle pulses, one pulse per mdc half period
`define SMI_CLK_DIV 4

// clause-22 frame constants
`define SMI_START      2'b01   // start of frame
`define SMI_TURNAROUND 2'b10   // master drives this on writes only

// bit positions inside the 32 bit frame, counted from 1
`define SMI_FRAME_BITS    6'd32  // last bit of a frame
`define SMI_RELEASE_BIT   6'd15  // read: mdio let go from here on
`define SMI_CAPTURE_BIT   6'd16  // read: bits after this are sampled
`define SMI_FINISH_PULSES 6'd3   // ticks spent in FINISH

`endif

// File: design/smiPkg.sv
package smiPkg;

    // clause-22 opcodes
    typedef enum logic [1:0] {
        opWrite = 2'b01,
        opRead  = 2'b10
    } smiOp;

    // field layout, msb first as on the wire
    typedef struct packed {
        logic [1:0]  start;      // 01
        smiOp        op;
        logic [4:0]  phyAddr;
        logic [4:0]  regAddr;
        logic [1:0]  turnaround; // 10 on writes
        logic [15:0] data;       // zero for reads
    } smiFields;

    // what the shift engine works with
    typedef struct packed {
        logic [15:0] upper;      // start .. turnaround
        logic [15:0] lower;      // data
    } smiHalves;

    // one frame word, seen either way
    typedef union packed {
        smiFields fields;        // builder side
        smiHalves halves;        // shift unit side
    } smiFrame;

endpackage

// File: design/smiIf.sv
`timescale 1ns/100ps

interface smiIf;

    import smiPkg::*;

    smiFrame     frame;          // frame word to send
    logic        transmitValid;  // frame waiting for the unit
    logic        transmitReady;  // one clock, frame taken
    logic [15:0] receiveData;    // read result, stable until next frame
    logic        receiveValid;   // one clock at end of a read
    logic        busy;           // unit not idle

    // request side
    modport builder (
        output frame, transmitValid,
        input  transmitReady, receiveData, receiveValid, busy
    );

    // shift engine side
    modport unit (
        input  frame, transmitValid,
        output transmitReady, receiveData, receiveValid, busy
    );

endinterface

// File: design/mdcTickGen.sv
`timescale 1ns/100ps
`include "smi_cfg.svh"

module mdcTickGen(
    input  logic clk,
    input  logic reset,
    output logic finalCycle    // one clock wide, every SMI_CLK_DIV clocks
    );

    // keep at least one bit even for a divide by one
    localparam int countBits = ($clog2(`SMI_CLK_DIV) > 0) ? $clog2(`SMI_CLK_DIV) : 1;
    localparam logic [countBits-1:0] reloadValue = countBits'(`SMI_CLK_DIV - 1);

    logic [countBits-1:0] count;   // counts down to zero

    // free running from reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count      <= reloadValue;
            finalCycle <= 1'b0;
        end else begin
            if (count == '0) begin
                count      <= reloadValue;  // wrap
                finalCycle <= 1'b1;         // tick
            end else begin
                count      <= count - 1'b1;
                finalCycle <= 1'b0;
            end
        end
    end

endmodule

// File: design/smiFrameBuilder.sv
`timescale 1ns/100ps
`include "smi_cfg.svh"

module smiFrameBuilder(
    input  logic        clk,
    input  logic        reset,
    input  logic        requestValid,  // one clock request strobe
    input  logic        requestWrite,  // 1 write, 0 read
    input  logic [4:0]  phyAddr,
    input  logic [4:0]  regAddr,
    input  logic [15:0] writeData,
    output logic [15:0] readData,      // valid with readDone
    output logic        readDone,      // one clock per finished read
    output logic        busy,          // transaction open
    smiIf.builder       unit
    );

    import smiPkg::*;

    smiFrame frameReg;          // latched request
    logic    transmitValidReg;
    logic    transactionOpen;
    logic    unitStarted;       // unit has taken the frame
    logic    accept;

    assign accept             = requestValid && !transactionOpen;  // ignored while busy
    assign busy               = transactionOpen;
    assign unit.frame         = frameReg;
    assign unit.transmitValid = transmitValidReg;

    // frame word, filled through the field view
    always_ff @(posedge clk) begin
        if (accept) begin
            frameReg.fields.start      <= `SMI_START;
            frameReg.fields.op         <= requestWrite ? opWrite : opRead;
            frameReg.fields.phyAddr    <= phyAddr;
            frameReg.fields.regAddr    <= regAddr;
            frameReg.fields.turnaround <= `SMI_TURNAROUND;
            frameReg.fields.data       <= requestWrite ? writeData : 16'h0000;  // reads send no data
        end
    end

    // request tracking
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            transmitValidReg <= 1'b0;
            transactionOpen  <= 1'b0;
            unitStarted      <= 1'b0;
            readDone         <= 1'b0;
        end else begin
            if (accept) begin
                transmitValidReg <= 1'b1;
                transactionOpen  <= 1'b1;
            end else if (unit.transmitReady) begin
                transmitValidReg <= 1'b0;  // unit has it now
                unitStarted      <= 1'b1;
            end else if (unitStarted && !unit.busy) begin
                transactionOpen  <= 1'b0;  // unit back in idle
                unitStarted      <= 1'b0;
            end
            readDone <= unit.receiveValid;  // one clock behind the unit
        end
    end

    // read result
    always_ff @(posedge clk) begin
        if (unit.receiveValid)
            readData <= unit.receiveData;
    end

endmodule

// File: design/ethernetSmiUnit.sv
`timescale 1ns/100ps
`include "smi_cfg.svh"

// reads send 14 header bits, let go of mdio, then shift in 16 data bits
// anything else is a plain 32 bit write
module ethernetSmiUnit(
    input  logic clk,
    input  logic reset,
    input  logic finalCycle,   // mdc half period tick
    smiIf.unit   host,
    output logic mdc,
    inout  wire  mdio
    );

    import smiPkg::*;

    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        CYCLE1 = 2'd1,   // mdc low, set data
        CYCLE2 = 2'd2,   // mdc high, capture data
        FINISH = 2'd3    // trailing mdc toggles
    } smiState;

    smiState     state;
    smiState     nextState;
    logic [5:0]  bitCounter;        // 1 .. 32
    logic [5:0]  bitCounterNext;
    logic [5:0]  idleCounter;       // finish pulses
    logic [5:0]  idleCounterNext;
    logic [15:0] upperDataReg;      // header half, rotates out msb first
    logic [15:0] upperDataRegNext;
    logic [15:0] lowerDataReg;      // data half, out on writes, in on reads
    logic [15:0] lowerDataRegNext;
    smiOp        opcodeReg;
    smiOp        opcodeRegNext;
    logic        transmitReadyReg;
    logic        transmitReadyRegNext;
    logic        receiveValidReg;
    logic        receiveValidRegNext;
    logic        mdcNext;
    logic        mdioIn;
    logic        mdioOutReg;
    logic        mdioOutRegNext;
    logic        mdioOutEnReg;
    logic        mdioOutEnRegNext;

    // control registers
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state            <= IDLE;
            bitCounter       <= 6'd1;
            idleCounter      <= 6'd1;
            opcodeReg        <= opWrite;
            transmitReadyReg <= 1'b0;
            receiveValidReg  <= 1'b0;
            mdc              <= 1'b0;   // mdc parked low
            mdioOutEnReg     <= 1'b0;   // mdio released
        end else begin
            state            <= nextState;
            bitCounter       <= bitCounterNext;
            idleCounter      <= idleCounterNext;
            opcodeReg        <= opcodeRegNext;
            transmitReadyReg <= transmitReadyRegNext;
            receiveValidReg  <= receiveValidRegNext;
            mdc              <= mdcNext;
            mdioOutEnReg     <= mdioOutEnRegNext;
        end
    end

    // shift data, only meaningful inside a frame
    always_ff @(posedge clk) begin
        upperDataReg <= upperDataRegNext;
        lowerDataReg <= lowerDataRegNext;
        mdioOutReg   <= mdioOutRegNext;
    end

    assign host.receiveData   = lowerDataReg;
    assign host.transmitReady = transmitReadyReg;
    assign host.receiveValid  = receiveValidReg;
    assign host.busy          = (state != IDLE);

    always_comb begin
        // hold everything unless a tick says otherwise
        nextState            = state;
        bitCounterNext       = bitCounter;
        idleCounterNext      = idleCounter;
        upperDataRegNext     = upperDataReg;
        lowerDataRegNext     = lowerDataReg;
        opcodeRegNext        = opcodeReg;
        mdcNext              = mdc;
        mdioOutRegNext       = mdioOutReg;
        mdioOutEnRegNext     = mdioOutEnReg;
        transmitReadyRegNext = 1'b0;   // pulses only
        receiveValidRegNext  = 1'b0;

        case (state)
            IDLE: begin
                bitCounterNext  = 6'd1;
                idleCounterNext = 6'd1;
                // frame taken on a tick only, keeps mdc phase clean
                if (host.transmitValid && finalCycle) begin
                    transmitReadyRegNext = 1'b1;
                    upperDataRegNext     = host.frame.halves.upper;
                    lowerDataRegNext     = host.frame.halves.lower;
                    opcodeRegNext        = smiOp'(host.frame.halves.upper[13:12]);  // frame bits 29:28
                    nextState            = CYCLE1;
                end
            end

            CYCLE1: begin
                if (finalCycle) begin
                    mdcNext = 1'b0;   // falling edge, slave samples on rise
                    if (opcodeReg == opRead) begin
                        if (bitCounter >= `SMI_RELEASE_BIT) begin
                            mdioOutEnRegNext = 1'b0;   // turnaround, phy owns the line
                        end else begin
                            mdioOutEnRegNext = 1'b1;
                            mdioOutRegNext   = upperDataReg[15];
                        end
                        if (bitCounter <= `SMI_CAPTURE_BIT)
                            upperDataRegNext = {upperDataReg[14:0], upperDataReg[15]};
                    end else begin
                        mdioOutEnRegNext = 1'b1;
                        mdioOutRegNext   = upperDataReg[15];
                        // whole 32 bits rotate as one word
                        {upperDataRegNext, lowerDataRegNext} =
                            {upperDataReg[14:0], lowerDataReg, upperDataReg[15]};
                    end
                    nextState = CYCLE2;
                end
            end

            CYCLE2: begin
                if (finalCycle) begin
                    mdcNext = 1'b1;   // rising edge
                    if ((opcodeReg == opRead) && (bitCounter > `SMI_CAPTURE_BIT))
                        lowerDataRegNext = {lowerDataReg[14:0], mdioIn};   // msb first
                    if (bitCounter == `SMI_FRAME_BITS) begin
                        receiveValidRegNext = (opcodeReg == opRead);
                        nextState           = FINISH;
                    end else begin
                        bitCounterNext = bitCounter + 6'd1;
                        nextState      = CYCLE1;
                    end
                end
            end

            FINISH: begin
                if (finalCycle) begin
                    mdcNext          = ~mdc;   // ends low after three toggles
                    mdioOutEnRegNext = 1'b0;   // write done, let go
                    idleCounterNext  = idleCounter + 6'd1;
                    if (idleCounter == `SMI_FINISH_PULSES)
                        nextState = IDLE;
                end
            end

            default: nextState = IDLE;
        endcase
    end

    // open drain style tristate, pullup is off chip
    assign mdio   = mdioOutEnReg ? mdioOutReg : 1'bz;
    assign mdioIn = mdio;

endmodule

// File: design/smiMaster.sv
`timescale 1ns/100ps

module smiMaster(
    input  logic        clk,
    input  logic        reset,
    input  logic        requestValid,  // accepted while busy is low
    input  logic        requestWrite,
    input  logic [4:0]  phyAddr,
    input  logic [4:0]  regAddr,
    input  logic [15:0] writeData,
    output logic [15:0] readData,
    output logic        readDone,
    output logic        busy,
    output logic        mdc,
    inout  wire         mdio
    );

    logic finalCycle;   // mdc half period tick

    smiIf smiBus();     // builder to shift engine

    mdcTickGen tickGen (
        .clk        (clk),
        .reset      (reset),
        .finalCycle (finalCycle)
    );

    smiFrameBuilder builder (
        .clk          (clk),
        .reset        (reset),
        .requestValid (requestValid),
        .requestWrite (requestWrite),
        .phyAddr      (phyAddr),
        .regAddr      (regAddr),
        .writeData    (writeData),
        .readData     (readData),
        .readDone     (readDone),
        .busy         (busy),
        .unit         (smiBus.builder)
    );

    ethernetSmiUnit smiUnit (
        .clk        (clk),
        .reset      (reset),
        .finalCycle (finalCycle),
        .host       (smiBus.unit),
        .mdc        (mdc),
        .mdio       (mdio)
    );

endmodule

// File: tests/phyModel.sv
`timescale 1ns/100ps

module phyModel(
    input logic mdc,
    inout wire  mdio
    );

    import smiPkg::*;

    localparam logic [4:0] ownAddr = 5'h03;   // the only address answered

    logic [15:0] regFile [32];
    logic [31:0] shiftIn;     // bits seen so far, newest in bit 0
    int          bitCount;    // 0 while hunting for a start bit
    logic [4:0]  regNum;      // register named in the header
    logic        answering;   // read to this phy in progress
    logic        writing;     // write to this phy in progress
    logic [15:0] readWord;
    logic        driveEn;
    logic        driveBit;

    assign mdio = driveEn ? driveBit : 1'bz;

    initial begin
        for (int i = 0; i < 32; i++)
            regFile[i] = {8'hA5, 8'(i)};   // reset contents
        shiftIn   = '0;
        bitCount  = 0;
        regNum    = '0;
        answering = 1'b0;
        writing   = 1'b0;
        readWord  = '0;
        driveEn   = 1'b0;
        driveBit  = 1'b1;
    end

    // everything happens on rising mdc, sample first then drive
    always @(posedge mdc) begin
        if (bitCount == 0) begin
            if (mdio === 1'b0) begin   // first start bit, idle line sits high
                shiftIn  = '0;
                bitCount = 1;
            end
        end else begin
            shiftIn  = {shiftIn[30:0], mdio};
            bitCount = bitCount + 1;
            if (bitCount == 14) begin
                // header: start [13:12], op [11:10], phy [9:5], reg [4:0]
                regNum    = shiftIn[4:0];
                answering = (shiftIn[13:12] == 2'b01) && (shiftIn[11:10] == opRead)
                            && (shiftIn[9:5] == ownAddr);
                writing   = (shiftIn[13:12] == 2'b01) && (shiftIn[11:10] == opWrite)
                            && (shiftIn[9:5] == ownAddr);
                readWord  = regFile[shiftIn[4:0]];
            end
            if (answering && (bitCount >= 16) && (bitCount < 32)) begin
                driveEn  = 1'b1;
                driveBit = readWord[31 - bitCount];   // msb first, master samples next rise
            end
            if (bitCount == 32) begin
                if (writing)
                    regFile[regNum] = shiftIn[15:0];
                driveEn   = 1'b0;   // let go of the line
                answering = 1'b0;
                writing   = 1'b0;
                bitCount  = 0;      // back to hunting
            end
        end
    end

endmodule

// File: tests/smiMasterTb.sv
`timescale 1ns/100ps
`include "smi_cfg.svh"

module smiMasterTb;

    localparam int numRequests = 50;   // accepted requests, 3 + 3 + 2 + 2 + 40
    localparam int cycleLimit  = (numRequests + 2) * 80 * `SMI_CLK_DIV;
    localparam logic [4:0] phyHere  = 5'h03;   // answered by the phy model
    localparam logic [4:0] phyEmpty = 5'h07;   // nobody home

    logic        clk;
    logic        reset;
    logic        requestValid;
    logic        requestWrite;
    logic [4:0]  phyAddr;
    logic [4:0]  regAddr;
    logic [15:0] writeData;
    logic [15:0] readData;
    logic        readDone;
    logic        busy;
    logic        mdc;
    wire         mdio;

    logic [15:0] shadow [32];   // mirror of the phy registers
    logic [15:0] pending [$];   // expected read results, oldest first
    int          readsIssued;
    int          readsDone;
    int          cycleCount;
    int          seed;

    smiMaster DUT (.*);
    phyModel phy (.mdc(mdc), .mdio(mdio));
    pullup (mdio);

    always #10 clk = ~clk;

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped");
    endtask

    // expected read value from the register rules
    function automatic logic [15:0] smiExpect(input logic [4:0] phyNum, input logic [4:0] regNum);
        if (phyNum == phyHere)
            return shadow[regNum];
        return 16'hFFFF;   // undriven bus reads the pullup
    endfunction

    // returns on a rising edge where busy was low
    task automatic waitIdle();
        @(posedge clk);
        while (busy)
            @(posedge clk);
    endtask

    task automatic issueRequest(input logic write, input logic [4:0] phyNum,
                                input logic [4:0] regNum, input logic [15:0] data);
        waitIdle();
        requestValid <= 1'b1;
        requestWrite <= write;
        phyAddr      <= phyNum;
        regAddr      <= regNum;
        writeData    <= data;
        if (!write) begin
            pending.push_back(smiExpect(phyNum, regNum));
            readsIssued++;
        end else if (phyNum == phyHere) begin
            shadow[regNum] = data;
        end
        @(posedge clk);
        requestValid <= 1'b0;
    endtask

    task automatic randomRequests(input int count);
        logic [31:0] r;
        logic        doWrite;
        logic [4:0]  phyNum;
        for (int i = 0; i < count; i++) begin
            r       = $random(seed);
            doWrite = r[0];
            r       = $random(seed);
            phyNum  = (doWrite || r[7]) ? phyHere : phyEmpty;   // writes only at phy 3
            issueRequest(doWrite, phyNum, r[4:0], r[31:16]);
        end
    endtask

    // compare at each readDone, sampled mid cycle
    always @(negedge clk) begin
        logic [15:0] expected;
        if (readDone) begin
            assert (pending.size() > 0)
                else abortRun("readDone pulsed with no read outstanding");
            expected = pending.pop_front();
            assert (readData === expected)
                else abortRun($sformatf("Error: readData 0x%04h, expected 0x%04h",
                                        readData, expected));
            readsDone++;
        end
    end

    // quiet bus between transactions
    always @(negedge clk) begin
        if (!reset && !busy) begin
            assert (mdc === 1'b0) else abortRun("mdc moved while the master was idle");
            assert (mdio === 1'b1) else abortRun("mdio was driven while the master was idle");
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        assert (cycleCount < cycleLimit)
            else abortRun($sformatf("timeout after %0d clock cycles", cycleCount));
    end

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        requestValid = 1'b0;
        requestWrite = 1'b0;
        phyAddr      = '0;
        regAddr      = '0;
        writeData    = '0;
        readsIssued  = 0;
        readsDone    = 0;
        cycleCount   = 0;
        seed         = 32'he7e10ed1;
        for (int i = 0; i < 32; i++)
            shadow[i] = {8'hA5, 8'(i)};   // phy reset contents
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        issueRequest(1'b0, phyHere, 5'd0, '0);    // untouched registers
        issueRequest(1'b0, phyHere, 5'd7, '0);
        issueRequest(1'b0, phyHere, 5'd31, '0);
        issueRequest(1'b1, phyHere, 5'd4, 16'h3C5A);   // write then read back
        issueRequest(1'b0, phyHere, 5'd4, '0);
        issueRequest(1'b0, phyHere, 5'd5, '0);    // neighbour unchanged
        issueRequest(1'b0, phyEmpty, 5'd4, '0);   // empty address
        issueRequest(1'b0, phyEmpty, 5'd0, '0);

        // strobes while busy must be dropped
        issueRequest(1'b0, phyHere, 5'd9, '0);
        repeat (10) @(posedge clk);
        assert (busy === 1'b1) else abortRun("busy did not rise for an accepted request");
        requestValid <= 1'b1;
        requestWrite <= 1'b1;
        phyAddr      <= phyHere;
        regAddr      <= 5'd4;
        writeData    <= ~shadow[4];
        @(posedge clk);
        requestWrite <= 1'b0;   // then a read, also dropped
        regAddr      <= 5'd2;
        @(posedge clk);
        requestValid <= 1'b0;
        issueRequest(1'b0, phyHere, 5'd4, '0);

        randomRequests(40);

        waitIdle();
        repeat (4) @(posedge clk);
        if ((pending.size() == 0) && (readsDone == readsIssued)) begin
            $display(">>> PASS");
            $finish;
        end else begin
            abortRun($sformatf("%0d reads issued but %0d readDone pulses seen",
                               readsIssued, readsDone));
        end
    end

endmodule

// File: list.f
+incdir+design
design/smiPkg.sv
design/smiIf.sv
design/mdcTickGen.sv
design/smiFrameBuilder.sv
design/ethernetSmiUnit.sv
design/smiMaster.sv
tests/phyModel.sv
tests/smiMasterTb.sv

// File: Bender.yml
package:
  name: smiMaster

export_include_dirs:
  - design

sources:
  - design/smiPkg.sv
  - design/smiIf.sv
  - design/mdcTickGen.sv
  - design/smiFrameBuilder.sv
  - design/ethernetSmiUnit.sv
  - design/smiMaster.sv
  - target: test
    files:
      - tests/phyModel.sv
      - tests/smiMasterTb.sv
